// File: design/fetchRequestStage.sv
/* fetch request capture
   holds the accepted address and slices it into tag, set and word */
`timescale 1ns/1ps
`include "icache_defs.svh"

module fetchRequestStage (
    input  logic                clk,
    input  logic                rst,
    input  logic                reqValid,
    input  icachePkg::fetchReqT reqData,
    output logic                reqReady,
    input  logic                busy,
    output icachePkg::lookupT   lookup,
    output logic                lookupValid,
    input  logic                done
);
    import icachePkg::*;

    logic      captured;
    fetchAddrT addrReg;

    // one request in flight, and none while a response waits
    assign reqReady = !captured && !busy;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            captured    <= 1'b0;
            lookupValid <= 1'b0;
        end else begin
            if (reqValid && reqReady) begin
                captured <= 1'b1;
            end else if (done) begin
                captured <= 1'b0;
            end
            // lookup runs in the cycle after capture
            lookupValid <= captured && !done;
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid && reqReady) begin
            addrReg <= reqData.addr;
        end
    end

    assign lookup.tag     = addrReg[`IC_ADDR_W-1 -: `IC_TAG_W];
    assign lookup.index   = addrReg[`IC_OFFSET_W +: `IC_INDEX_W];
    assign lookup.wordSel = addrReg[`IC_OFFSET_W-1];

    // requester keeps its payload until accepted
    assert property (@(posedge clk) disable iff (!rst)
        (reqValid && !reqReady) |=> $stable(reqData));

endmodule

// File: design/fetchResponseStage.sv
/* fetch response register
   holds instruction and hit flag under back-pressure */
`timescale 1ns/1ps

module fetchResponseStage (
    input  logic                clk,
    input  logic                rst,
    input  logic                rspLoad,
    input  icachePkg::instrT    rspInstr,
    input  logic                rspHit,
    output logic                rspValid,
    output icachePkg::fetchRspT rspData,
    input  logic                rspReady,
    output logic                busy
);
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rspValid <= 1'b0;
        end else if (rspLoad) begin
            rspValid <= 1'b1;
        end else if (rspReady) begin
            rspValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rspLoad) begin
            rspData.instr <= rspInstr;
            rspData.hit   <= rspHit;
        end
    end

    // request side stays closed until the handshake
    assign busy = rspValid;

    assert property (@(posedge clk) disable iff (!rst) rspLoad |-> !rspValid);

endmodule

// File: design/icacheArray.sv
/* set-associative tag and data array with bit-per-way pseudo-LRU,
   combinational lookup and victim choice, synchronous fill and MRU update */
`timescale 1ns/1ps
`include "icache_defs.svh"

module icacheArray (
    input  logic              clk,
    input  logic              rst,
    input  icachePkg::lookupT lookup,
    input  logic              lookupValid,
    output logic              hit,
    output icachePkg::blockT  hitBlock,
    input  logic              touchEn,
    input  logic              fillEn,
    input  icachePkg::blockT  fillBlock
);
    import icachePkg::*;

    // state columns, one entry per set
    wayMaskT validCol [`IC_SETS];
    wayMaskT mruCol   [`IC_SETS];
    tagT     tagCol   [`IC_SETS][`IC_WAYS];
    blockT   dataCol  [`IC_SETS][`IC_WAYS];

    wayMaskT hitMask;
    wayMaskT victim;
    wayMaskT candidates;

    // set the chosen way, or restart the set when every bit would be one
    function automatic wayMaskT nextMru(wayMaskT cur, wayMaskT sel);
        wayMaskT upd;
        upd = cur | sel;
        return (&upd) ? sel : upd;
    endfunction

    always_comb begin
        hitMask  = '0;
        hitBlock = '0;
        for (int w = 0; w < `IC_WAYS; w++) begin
            hitMask[w] = lookupValid && validCol[lookup.index][w] &&
                         (tagCol[lookup.index][w] == lookup.tag);
        end
        for (int w = 0; w < `IC_WAYS; w++) begin
            if (hitMask[w]) begin
                hitBlock = dataCol[lookup.index][w];
            end
        end
    end

    assign hit = |hitMask;

    // lowest invalid way first, else lowest way not recently used
    always_comb begin
        if (&validCol[lookup.index]) begin
            candidates = ~mruCol[lookup.index];
        end else begin
            candidates = ~validCol[lookup.index];
        end
        victim = candidates & (~candidates + 1'b1);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `IC_SETS; s++) begin
                validCol[s] <= '0;
                mruCol[s]   <= '0;
            end
        end else if (touchEn) begin
            mruCol[lookup.index] <= nextMru(mruCol[lookup.index], hitMask);
        end else if (fillEn) begin
            validCol[lookup.index] <= validCol[lookup.index] | victim;
            mruCol[lookup.index]   <= nextMru(mruCol[lookup.index], victim);
        end
    end

    always_ff @(posedge clk) begin
        if (fillEn) begin
            for (int w = 0; w < `IC_WAYS; w++) begin
                if (victim[w]) begin
                    tagCol[lookup.index][w]  <= lookup.tag;
                    dataCol[lookup.index][w] <= fillBlock;
                end
            end
        end
    end

    // controller serializes hits and refills
    assert property (@(posedge clk) disable iff (!rst) !(touchEn && fillEn));

    // a tag lives in at most one way of a set
    assert property (@(posedge clk) disable iff (!rst) $onehot0(hitMask));

endmodule

// File: design/icachePkg.sv
/* vector types, packed fetch, lookup and AXI4-Lite structs,
   refill FSM state encoding */
`include "icache_defs.svh"

package icachePkg;

    typedef logic [`IC_ADDR_W-1:0] fetchAddrT;
    typedef logic [`IC_TAG_W-1:0] tagT;
    typedef logic [`IC_INDEX_W-1:0] setIdxT;
    typedef logic [`IC_WAYS-1:0] wayMaskT;
    typedef logic [`IC_WORD_W-1:0] instrT;
    typedef logic [`IC_BLOCK_W-1:0] blockT;

    typedef struct packed {
        fetchAddrT addr;
    } fetchReqT;

    // hit is low when the answer needed a refill
    typedef struct packed {
        instrT instr;
        logic  hit;
    } fetchRspT;

    typedef struct packed {
        tagT    tag;
        setIdxT index;
        logic   wordSel;
    } lookupT;

    typedef struct packed {
        fetchAddrT  araddr;
        logic [2:0] arprot;
    } axiArT;

    typedef struct packed {
        instrT      rdata;
        logic [1:0] rresp;
    } axiRT;

    typedef enum logic [2:0] {IDLE, REQ_LO, WAIT_LO, REQ_HI, WAIT_HI, FILL} refillStateT;

endpackage

// File: design/icache_defs.svh
/* geometry macros for the instruction cache
   address, set, way, block and word widths */
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// byte address width of the fetch port
`define IC_ADDR_W 16
`define IC_SETS 8
`define IC_WAYS 4
// one block holds two instruction words
`define IC_BLOCK_W 64
`define IC_WORD_W 32

// byte offset inside a block, bits 2 to 0
`define IC_OFFSET_W ($clog2(`IC_BLOCK_W / 8))
`define IC_INDEX_W ($clog2(`IC_SETS))
// tag sits in bits 15 to 6
`define IC_TAG_W (`IC_ADDR_W - `IC_INDEX_W - `IC_OFFSET_W)

`endif

// File: design/instrCacheTop.sv
/* blocking instruction cache top
   fetch valid/ready port and AXI4-Lite read master */
`timescale 1ns/1ps

module instrCacheTop (
    input  logic                clk,
    input  logic                rst,
    input  logic                reqValid,
    input  icachePkg::fetchReqT reqData,
    output logic                reqReady,
    output logic                rspValid,
    output icachePkg::fetchRspT rspData,
    input  logic                rspReady,
    output logic                arValid,
    output icachePkg::axiArT    arData,
    input  logic                arReady,
    input  logic                rValid,
    input  icachePkg::axiRT     rData,
    output logic                rReady
);
    import icachePkg::*;

    lookupT lookup;
    logic   lookupValid;
    logic   hit;
    blockT  hitBlock;
    logic   touchEn;
    logic   fillEn;
    blockT  fillBlock;
    logic   rspLoad;
    instrT  rspInstr;
    logic   rspHit;
    logic   done;
    logic   busy;

    fetchRequestStage reqStage (
        .clk(clk), .rst(rst), .reqValid(reqValid), .reqData(reqData), .reqReady(reqReady),
        .busy(busy), .lookup(lookup), .lookupValid(lookupValid), .done(done)
    );

    icacheArray array (
        .clk(clk), .rst(rst), .lookup(lookup), .lookupValid(lookupValid), .hit(hit),
        .hitBlock(hitBlock), .touchEn(touchEn), .fillEn(fillEn), .fillBlock(fillBlock)
    );

    refillController refill (
        .clk(clk), .rst(rst), .lookupValid(lookupValid), .hit(hit), .hitBlock(hitBlock),
        .wordSel(lookup.wordSel), .fillEn(fillEn), .fillBlock(fillBlock), .touchEn(touchEn),
        .rspLoad(rspLoad), .rspInstr(rspInstr), .rspHit(rspHit), .done(done),
        .arValid(arValid), .arData(arData), .arReady(arReady), .rValid(rValid),
        .rData(rData), .rReady(rReady), .tagIdx(lookup)
    );

    fetchResponseStage rspStage (
        .clk(clk), .rst(rst), .rspLoad(rspLoad), .rspInstr(rspInstr), .rspHit(rspHit),
        .rspValid(rspValid), .rspData(rspData), .rspReady(rspReady), .busy(busy)
    );

endmodule

// File: design/refillController.sv
/* miss FSM with two AXI4-Lite reads per block refill,
   hit/MRU pulses and response word select */
`timescale 1ns/1ps
`include "icache_defs.svh"

module refillController (
    input  logic              clk,
    input  logic              rst,
    input  logic              lookupValid,
    input  logic              hit,
    input  icachePkg::blockT  hitBlock,
    input  logic              wordSel,
    output logic              fillEn,
    output icachePkg::blockT  fillBlock,
    output logic              touchEn,
    output logic              rspLoad,
    output icachePkg::instrT  rspInstr,
    output logic              rspHit,
    output logic              done,
    output logic              arValid,
    output icachePkg::axiArT  arData,
    input  logic              arReady,
    input  logic              rValid,
    input  icachePkg::axiRT   rData,
    output logic              rReady,
    input  icachePkg::lookupT tagIdx
);
    import icachePkg::*;

    refillStateT state;
    refillStateT nextState;
    logic        missSeen;
    fetchAddrT   blockBase;

    always_comb begin
        nextState = state;
        case (state)
            IDLE:    if (lookupValid && !hit) nextState = REQ_LO;
            REQ_LO:  if (arReady) nextState = WAIT_LO;
            WAIT_LO: if (rValid) nextState = REQ_HI;
            REQ_HI:  if (arReady) nextState = WAIT_HI;
            WAIT_HI: if (rValid) nextState = FILL;
            FILL:    nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= IDLE;
            missSeen <= 1'b0;
        end else begin
            state <= nextState;
            if (rspLoad) begin
                missSeen <= 1'b0;
            end else if (state == IDLE && lookupValid && !hit) begin
                missSeen <= 1'b1;
            end
        end
    end

    // low word lands in the low half
    always_ff @(posedge clk) begin
        if (state == WAIT_LO && rValid) begin
            fillBlock[0 +: `IC_WORD_W] <= rData.rdata;
        end
        if (state == WAIT_HI && rValid) begin
            fillBlock[`IC_WORD_W +: `IC_WORD_W] <= rData.rdata;
        end
    end

    assign blockBase = {tagIdx.tag, tagIdx.index, {`IC_OFFSET_W{1'b0}}};

    assign arValid = (state == REQ_LO) || (state == REQ_HI);
    assign rReady  = (state == WAIT_LO) || (state == WAIT_HI);
    assign arData.araddr = (state == REQ_HI) ? blockBase + fetchAddrT'(`IC_WORD_W / 8)
                                             : blockBase;
    // unprivileged, secure, instruction access
    assign arData.arprot = 3'b100;

    assign fillEn = (state == FILL);

    // after a fill the same lookup hits and answers from the array
    assign rspLoad  = (state == IDLE) && lookupValid && hit;
    assign touchEn  = rspLoad && !missSeen;
    assign rspHit   = !missSeen;
    assign done     = rspLoad;
    assign rspInstr = wordSel ? hitBlock[`IC_WORD_W +: `IC_WORD_W] : hitBlock[0 +: `IC_WORD_W];

    assert property (@(posedge clk) disable iff (!rst)
        (arValid && !arReady) |=> (arValid && $stable(arData.araddr)));

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and pass only on the pass message
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tbInstrCache -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
    && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: verification/axiLiteMemModel.sv
/* read-only AXI4-Lite memory model
   word content is the word address XOR A5A50000, random R delay */
`timescale 1ns/1ps

module axiLiteMemModel (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      seed,
    input  logic             arValid,
    input  icachePkg::axiArT arData,
    output logic             arReady,
    output logic             rValid,
    output icachePkg::axiRT  rData,
    input  logic             rReady
);
    import icachePkg::*;

    logic [31:0] rng;
    logic        pending;
    int          delayLeft;
    logic        inReset;
    logic        arFire;
    logic        rFire;
    fetchAddrT   addrNow;

    initial begin
        arReady   = 1'b0;
        rValid    = 1'b0;
        rData     = '0;
        pending   = 1'b0;
        delayLeft = 0;
        rng       = '0;
        forever begin
            @(posedge clk);
            inReset = !rst;
            arFire  = arValid && arReady;
            rFire   = rValid && rReady;
            addrNow = arData.araddr;
            // outputs change shortly after the edge
            #1;
            if (inReset) begin
                rng     = seed;
                pending = 1'b0;
                rValid  = 1'b0;
                arReady = 1'b0;
            end else begin
                if (rFire) begin
                    rValid = 1'b0;
                end
                if (arFire) begin
                    // xorshift32 step for the response delay
                    rng = rng ^ (rng << 13);
                    rng = rng ^ (rng >> 17);
                    rng = rng ^ (rng << 5);
                    delayLeft   = int'(rng % 4);
                    pending     = 1'b1;
                    rData.rdata = 32'(addrNow >> 2) ^ 32'hA5A50000;
                    rData.rresp = 2'b00;
                end
                if (pending) begin
                    if (delayLeft == 0) begin
                        rValid  = 1'b1;
                        pending = 1'b0;
                    end else begin
                        delayLeft--;
                    end
                end
                // one read at a time
                arReady = !pending && !rValid;
            end
        end
    end

endmodule

// File: verification/tbInstrCache.sv
/* instruction cache testbench
   reference cache model, directed and random fetches, timeout */
`timescale 1ns/1ps
`include "icache_defs.svh"

module tbInstrCache;
    import icachePkg::*;

    localparam int COLD_N = 6;
    localparam int REPL_N = 12;
    localparam int BP_N = 12;
    localparam int RAND_N = 400;
    // cold, hit, replacement, back-pressure and random fetches
    localparam int REQ_TOTAL = COLD_N + 2 + REPL_N + BP_N + RAND_N;
    localparam int CYCLE_LIMIT = 200 * REQ_TOTAL;

    logic     clk = 1'b0;
    logic     rst;
    logic     reqValid;
    fetchReqT reqData;
    logic     reqReady;
    logic     rspValid;
    fetchRspT rspData;
    logic     rspReady;
    logic     arValid;
    axiArT    arData;
    logic     arReady;
    logic     rValid;
    axiRT     rData;
    logic     rReady;

    logic [31:0] rngState;
    logic [31:0] memSeed;
    logic        stallOn;
    int          cycle = 0;
    int          arCount = 0;
    logic        readOpen = 1'b0;

    // reference model state
    wayMaskT mValid [`IC_SETS];
    wayMaskT mMru   [`IC_SETS];
    tagT     mTag   [`IC_SETS][`IC_WAYS];

    instrCacheTop dut (.*);

    axiLiteMemModel mem (
        .clk(clk), .rst(rst), .seed(memSeed), .arValid(arValid), .arData(arData),
        .arReady(arReady), .rValid(rValid), .rData(rData), .rReady(rReady)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle++;
        // a read is open from its AR handshake to its R handshake
        if (rReady) begin
            checkEq("rReady with no read open", 1, readOpen);
        end
        if (arValid && arReady) begin
            arCount++;
            readOpen = 1'b1;
        end
        if (rValid && rReady) begin
            readOpen = 1'b0;
        end
        if (cycle > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] drawRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    task automatic checkEq(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // hit or miss by the MRU-bit rule, then update the model
    task automatic predict(input fetchAddrT addr, output logic isHit);
        setIdxT s;
        tagT    t;
        int     way;
        s = addr[5:3];
        t = addr[15:6];
        way = -1;
        for (int w = 0; w < `IC_WAYS; w++) begin
            if (mValid[s][w] && mTag[s][w] == t) way = w;
        end
        isHit = (way >= 0);
        if (!isHit) begin
            for (int w = `IC_WAYS - 1; w >= 0; w--) begin
                if (&mValid[s] ? !mMru[s][w] : !mValid[s][w]) way = w;
            end
            mValid[s][way] = 1'b1;
            mTag[s][way]   = t;
        end
        mMru[s][way] = 1'b1;
        if (&mMru[s]) mMru[s] = wayMaskT'(1 << way);
    endtask

    task automatic fetchOne(input string name, input fetchAddrT addr);
        logic     expHit;
        logic     ready;
        logic     seen;
        int       arBefore;
        int       startCycle;
        fetchRspT held;
        predict(addr, expHit);
        seen = 1'b0;
        reqValid = 1'b1;
        reqData.addr = addr;
        do begin
            @(negedge clk);
            ready = reqReady;
            startCycle = cycle + 1;
            arBefore = arCount;
            @(posedge clk);
        end while (!ready);
        #1;
        reqValid = 1'b0;
        forever begin
            @(negedge clk);
            if (rspValid) begin
                if (!seen) begin
                    checkEq({name, " instr"}, 32'(addr >> 2) ^ 32'hA5A50000, rspData.instr);
                    checkEq({name, " hit"}, expHit, rspData.hit);
                    checkEq({name, " AR count"}, expHit ? 0 : 2, arCount - arBefore);
                    if (expHit) checkEq({name, " hit latency"}, 2, cycle - startCycle);
                    held = rspData;
                    seen = 1'b1;
                end else begin
                    checkEq({name, " held response"}, held, rspData);
                end
                checkEq({name, " reqReady while pending"}, 0, reqReady);
                if (rspReady) break;
            end
            @(posedge clk);
            #1;
            rspReady = !stallOn || (drawRandom() % 3 == 0);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        int replTags [REPL_N];
        replTags = '{1, 2, 3, 4, 1, 5, 2, 3, 1, 4, 5, 2};
        rst = 1'b0;
        reqValid = 1'b0;
        reqData = '0;
        rspReady = 1'b0;
        stallOn = 1'b0;
        rngState = 32'he3f7;
        memSeed = drawRandom();
        for (int s = 0; s < `IC_SETS; s++) begin
            mValid[s] = '0;
            mMru[s] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;
        rspReady = 1'b1;
        // one block in each of sets 0 to 5
        for (int i = 0; i < COLD_N; i++) fetchOne("cold miss", fetchAddrT'(i * 'h48));
        fetchOne("hit high word", 16'h0004);
        fetchOne("hit low word", 16'h0000);
        // five tags competing for set 6
        for (int i = 0; i < REPL_N; i++) begin
            fetchOne("replacement", fetchAddrT'((replTags[i] << 6) | (6 << 3)));
        end
        stallOn = 1'b1;
        for (int i = 0; i < BP_N; i++) begin
            fetchOne("back-pressure", fetchAddrT'(drawRandom() & 16'h00FC));
        end
        for (int i = 0; i < RAND_N; i++) begin
            fetchOne("random", fetchAddrT'(drawRandom() & 16'h03FC));
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+design
design/icachePkg.sv
design/fetchRequestStage.sv
design/icacheArray.sv
design/refillController.sv
design/fetchResponseStage.sv
design/instrCacheTop.sv
verification/axiLiteMemModel.sv
verification/tbInstrCache.sv
